/* rtl/pipe_ctrl_settings.svh */
// pipeline control settings: widths and stage index constants for the seven-stage core
`ifndef PIPE_CTRL_SETTINGS_SVH
`define PIPE_CTRL_SETTINGS_SVH

`define PC_STAGES   7   // preif, if, id, exe, mem, mem2, wb
`define PC_ADDR_W   32  // data address width
`define PC_REG_W    5   // gpr number width
`define PC_WORD_LSB 2   // word match ignores byte offset

// bit positions inside a stage mask
`define PC_S_PREIF  0
`define PC_S_IF     1
`define PC_S_ID     2
`define PC_S_EXE    3
`define PC_S_MEM    4
`define PC_S_MEM2   5
`define PC_S_WB     6

`endif

/* rtl/pipe_ctrl_pkg.sv */
// pipeline control package: shared vector types and the stall/flush cause encoding
`include "pipe_ctrl_settings.svh"

package pipe_ctrl_pkg;

    typedef logic [`PC_STAGES-1:0] stage_mask_t; // one bit per stage
    typedef logic [`PC_ADDR_W-1:0] addr_t;       // data address
    typedef logic [`PC_REG_W-1:0]  reg_idx_t;    // register number

    // winning cause, highest priority first after none
    typedef enum logic [3:0] {
        cause_none,
        cause_exception,
        cause_dstall,
        cause_store_conflict,
        cause_muldiv,
        cause_load_use,
        cause_istall,
        cause_branch,
        cause_jump
    } cause_e;

endpackage

/* rtl/store_slot_if.sv */
// store slot bundle: pending stores held in the memory-two and write-back stages
`timescale 1ns/1ns

interface store_slot_if;

    pipe_ctrl_pkg::addr_t mem2_addr;   // word address of mem2 entry
    logic                 mem2_store;  // mem2 holds a store
    logic                 mem2_cached; // mem2 store goes through dcache
    pipe_ctrl_pkg::addr_t wb_addr;
    logic                 wb_store;
    logic                 wb_cached;

    modport track (
        output mem2_addr, mem2_store, mem2_cached,
        output wb_addr, wb_store, wb_cached
    );

    modport detect (
        input mem2_addr, mem2_store, mem2_cached,
        input wb_addr, wb_store, wb_cached
    );

endinterface

/* rtl/store_track.sv */
// store tracker: follows memory-stage stores through memory-two and write-back
`timescale 1ns/1ns
`include "pipe_ctrl_settings.svh"

module store_track (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  pipe_ctrl_pkg::stage_mask_t stage_wr,
    input  pipe_ctrl_pkg::stage_mask_t stage_flush,
    input  pipe_ctrl_pkg::addr_t       mem_addr,
    input  logic                       mem_store,
    input  logic                       mem_cached,
    store_slot_if.track                slots
);

    logic mem2_wr;
    logic mem2_flush;
    logic wb_wr;
    logic wb_flush;

    assign mem2_wr    = stage_wr[`PC_S_MEM2];
    assign mem2_flush = stage_flush[`PC_S_MEM2];
    assign wb_wr      = stage_wr[`PC_S_WB];
    assign wb_flush   = stage_flush[`PC_S_WB];

    // store flags and cache attribute
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            slots.mem2_store  <= 1'b0;
            slots.mem2_cached <= 1'b0;
            slots.wb_store    <= 1'b0;
            slots.wb_cached   <= 1'b0;
        end else begin
            if (mem2_wr) begin
                slots.mem2_store  <= mem_store & ~mem2_flush; // flush inserts a bubble
                slots.mem2_cached <= mem_cached;
            end
            if (wb_wr) begin
                slots.wb_store  <= slots.mem2_store & ~wb_flush;
                slots.wb_cached <= slots.mem2_cached;
            end
        end
    end

    // address payload follows the same enables
    always_ff @(posedge aclk) begin
        if (mem2_wr) begin
            slots.mem2_addr <= mem_addr;
        end
        if (wb_wr) begin
            slots.wb_addr <= slots.mem2_addr; // old mem2 entry moves on
        end
    end

endmodule

/* rtl/hazard_detect.sv */
// hazard detector: load-use against the memory stage and uncached store/load overlap
`timescale 1ns/1ns
`include "pipe_ctrl_settings.svh"

module hazard_detect (
    input  pipe_ctrl_pkg::reg_idx_t id_rs,
    input  pipe_ctrl_pkg::reg_idx_t id_rt,
    input  pipe_ctrl_pkg::reg_idx_t mem_rt,
    input  logic                    mem_load,
    input  logic                    mem_req,
    input  pipe_ctrl_pkg::addr_t    mem_addr,
    input  logic                    mem_cached,
    store_slot_if.detect            slots,
    output logic                    load_use,
    output logic                    store_conflict
);

    logic rt_nonzero;
    logic rt_match;
    logic mem2_hit;
    logic wb_hit;

    // r0 is hardwired, never a real dependence
    assign rt_nonzero = (mem_rt != '0);
    assign rt_match   = (mem_rt == id_rs) || (mem_rt == id_rt);
    assign load_use   = mem_load & rt_nonzero & rt_match;

    // word compare, byte offset ignored
    assign mem2_hit = slots.mem2_store &&
        (slots.mem2_addr[`PC_ADDR_W-1:`PC_WORD_LSB] == mem_addr[`PC_ADDR_W-1:`PC_WORD_LSB]);
    assign wb_hit   = slots.wb_store &&
        (slots.wb_addr[`PC_ADDR_W-1:`PC_WORD_LSB] == mem_addr[`PC_ADDR_W-1:`PC_WORD_LSB]);

    // uncached access must wait until older store to same word has left
    assign store_conflict = mem_req & ~mem_cached & (mem2_hit | wb_hit);

endmodule

/* rtl/stall_arbiter.sv */
// stall arbiter: fixed-priority cause select and per-stage write enable / flush masks
`timescale 1ns/1ns
`include "pipe_ctrl_settings.svh"

module stall_arbiter (
    input  logic                       exception,
    input  logic                       dcache_busy,
    input  logic                       d_tlb_stall,
    input  logic                       store_conflict,
    input  logic                       muldiv_busy,
    input  logic                       load_use,
    input  logic                       icache_busy,
    input  logic                       i_tlb_stall,
    input  logic                       branch_failed,
    input  logic                       imm_jump,
    input  logic                       mem_req,
    output pipe_ctrl_pkg::stage_mask_t stage_wr,
    output pipe_ctrl_pkg::stage_mask_t stage_flush,
    output pipe_ctrl_pkg::cause_e      cause,
    output logic                       dreq_valid,
    output logic                       ireq_valid
);

    // priority select, first active cause wins
    always_comb begin
        if (exception) begin
            cause = pipe_ctrl_pkg::cause_exception;
        end else if (dcache_busy || d_tlb_stall) begin
            cause = pipe_ctrl_pkg::cause_dstall;
        end else if (store_conflict) begin
            cause = pipe_ctrl_pkg::cause_store_conflict;
        end else if (muldiv_busy) begin
            cause = pipe_ctrl_pkg::cause_muldiv;
        end else if (load_use) begin
            cause = pipe_ctrl_pkg::cause_load_use;
        end else if (icache_busy || i_tlb_stall) begin
            cause = pipe_ctrl_pkg::cause_istall;
        end else if (branch_failed) begin
            cause = pipe_ctrl_pkg::cause_branch;
        end else if (imm_jump) begin
            cause = pipe_ctrl_pkg::cause_jump;
        end else begin
            cause = pipe_ctrl_pkg::cause_none;
        end
    end

    // mask table, default is free running
    always_comb begin
        stage_wr    = '1;
        stage_flush = '0;
        case (cause)
            pipe_ctrl_pkg::cause_exception: begin
                stage_flush[`PC_S_MEM:`PC_S_IF] = '1; // squash everything before mem2
            end
            pipe_ctrl_pkg::cause_dstall: begin
                stage_wr = '0; // whole pipe frozen
            end
            pipe_ctrl_pkg::cause_store_conflict: begin
                stage_wr[`PC_S_MEM:`PC_S_PREIF] = '0;
                stage_flush[`PC_S_MEM2]         = 1'b1; // let older stores drain
            end
            pipe_ctrl_pkg::cause_muldiv: begin
                stage_wr[`PC_S_EXE:`PC_S_PREIF] = '0;
                stage_flush[`PC_S_MEM]          = 1'b1;
            end
            pipe_ctrl_pkg::cause_load_use: begin
                stage_wr[`PC_S_ID:`PC_S_PREIF] = '0;
                stage_flush[`PC_S_EXE]         = 1'b1; // bubble behind the load
            end
            pipe_ctrl_pkg::cause_istall: begin
                stage_wr[`PC_S_IF:`PC_S_PREIF] = '0;
                stage_flush[`PC_S_ID]          = 1'b1;
            end
            pipe_ctrl_pkg::cause_branch: begin
                stage_flush[`PC_S_ID:`PC_S_IF] = '1; // wrong-path fetches
            end
            pipe_ctrl_pkg::cause_jump: begin
                stage_flush[`PC_S_IF] = 1'b1; // only the slot after delay slot
            end
            default: begin
                stage_wr    = '1;
                stage_flush = '0;
            end
        endcase
    end

    assign dreq_valid = mem_req & ~(exception | store_conflict);
    assign ireq_valid = stage_wr[`PC_S_PREIF]; // fetch only when pc advances

endmodule

/* rtl/pipe_ctrl_top.sv */
// pipeline control top: hazard detection, store tracking and stall arbitration
`timescale 1ns/1ns

module pipe_ctrl_top (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       exception,
    input  logic                       dcache_busy,
    input  logic                       d_tlb_stall,
    input  logic                       muldiv_busy,
    input  logic                       icache_busy,
    input  logic                       i_tlb_stall,
    input  logic                       branch_failed,
    input  logic                       imm_jump,
    input  pipe_ctrl_pkg::reg_idx_t    id_rs,
    input  pipe_ctrl_pkg::reg_idx_t    id_rt,
    input  pipe_ctrl_pkg::reg_idx_t    mem_rt,
    input  logic                       mem_load,
    input  logic                       mem_req,
    input  logic                       mem_store,
    input  pipe_ctrl_pkg::addr_t       mem_addr,
    input  logic                       mem_cached,
    output pipe_ctrl_pkg::stage_mask_t stage_wr,
    output pipe_ctrl_pkg::stage_mask_t stage_flush,
    output pipe_ctrl_pkg::cause_e      cause,
    output logic                       dreq_valid,
    output logic                       ireq_valid
);

    logic load_use;       // from hazard_detect
    logic store_conflict; // from hazard_detect

    store_slot_if slot_bus ();

    store_track u_store_track (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .stage_wr       (stage_wr),
        .stage_flush    (stage_flush),
        .mem_addr       (mem_addr),
        .mem_store      (mem_store),
        .mem_cached     (mem_cached),
        .slots          (slot_bus.track)
    );

    hazard_detect u_hazard_detect (
        .id_rs          (id_rs),
        .id_rt          (id_rt),
        .mem_rt         (mem_rt),
        .mem_load       (mem_load),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_cached     (mem_cached),
        .slots          (slot_bus.detect),
        .load_use       (load_use),
        .store_conflict (store_conflict)
    );

    stall_arbiter u_stall_arbiter (
        .exception      (exception),
        .dcache_busy    (dcache_busy),
        .d_tlb_stall    (d_tlb_stall),
        .store_conflict (store_conflict),
        .muldiv_busy    (muldiv_busy),
        .load_use       (load_use),
        .icache_busy    (icache_busy),
        .i_tlb_stall    (i_tlb_stall),
        .branch_failed  (branch_failed),
        .imm_jump       (imm_jump),
        .mem_req        (mem_req),
        .stage_wr       (stage_wr),
        .stage_flush    (stage_flush),
        .cause          (cause),
        .dreq_valid     (dreq_valid),
        .ireq_valid     (ireq_valid)
    );

endmodule

/* test/tb_pipe_ctrl_top.sv */
// pipeline control testbench driving directed and random rows against a store slot model
`timescale 1ns/1ns
`include "pipe_ctrl_settings.svh"

module tb_pipe_ctrl_top;

    logic                       aclk;
    logic                       rst_n;
    logic [7:0]                 causes; // exc, dcache, dtlb, muldiv, icache, itlb, branch, jump
    pipe_ctrl_pkg::reg_idx_t    id_rs;
    pipe_ctrl_pkg::reg_idx_t    id_rt;
    pipe_ctrl_pkg::reg_idx_t    mem_rt;
    logic                       mem_load;
    logic                       mem_req;
    logic                       mem_store;
    logic                       mem_cached;
    pipe_ctrl_pkg::addr_t       mem_addr;
    pipe_ctrl_pkg::stage_mask_t stage_wr;
    pipe_ctrl_pkg::stage_mask_t stage_flush;
    pipe_ctrl_pkg::cause_e      cause;
    logic                       dreq_valid;
    logic                       ireq_valid;

    // stimulus table with one entry per row in each queue
    string                      t_name[$];
    logic [7:0]                 t_causes[$];
    logic [14:0]                t_regs[$];  // rs, rt, mem_rt
    logic [3:0]                 t_mem[$];   // load, req, store, cached
    pipe_ctrl_pkg::addr_t       t_addr[$];
    pipe_ctrl_pkg::stage_mask_t t_wr[$];
    pipe_ctrl_pkg::stage_mask_t t_flush[$];
    pipe_ctrl_pkg::cause_e      t_cause[$];
    logic                       t_dreq[$];
    int                         t_steps[$];
    logic                       t_model[$]; // expected values from the slot model

    pipe_ctrl_pkg::addr_t       m2_addr;    // slot model
    pipe_ctrl_pkg::addr_t       wb_addr;
    logic                       m2_st;
    logic                       wb_st;
    int                         row_errors;
    int                         tests_pass;
    int                         tests_fail;
    longint                     limit_ns;

    pipe_ctrl_top u_pipe_ctrl_top (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .exception     (causes[7]),
        .dcache_busy   (causes[6]),
        .d_tlb_stall   (causes[5]),
        .muldiv_busy   (causes[4]),
        .icache_busy   (causes[3]),
        .i_tlb_stall   (causes[2]),
        .branch_failed (causes[1]),
        .imm_jump      (causes[0]),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .mem_rt        (mem_rt),
        .mem_load      (mem_load),
        .mem_req       (mem_req),
        .mem_store     (mem_store),
        .mem_addr      (mem_addr),
        .mem_cached    (mem_cached),
        .stage_wr      (stage_wr),
        .stage_flush   (stage_flush),
        .cause         (cause),
        .dreq_valid    (dreq_valid),
        .ireq_valid    (ireq_valid)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task automatic add_row(input string name, input logic [7:0] c, input logic [14:0] regs,
                           input logic [3:0] mem, input pipe_ctrl_pkg::addr_t addr,
                           input pipe_ctrl_pkg::stage_mask_t wr,
                           input pipe_ctrl_pkg::stage_mask_t fl,
                           input pipe_ctrl_pkg::cause_e exp_cause, input logic dreq,
                           input int steps, input logic use_model);
        t_name.push_back(name);
        t_causes.push_back(c);
        t_regs.push_back(regs);
        t_mem.push_back(mem);
        t_addr.push_back(addr);
        t_wr.push_back(wr);
        t_flush.push_back(fl);
        t_cause.push_back(exp_cause);
        t_dreq.push_back(dreq);
        t_steps.push_back(steps);
        t_model.push_back(use_model);
    endtask

    task automatic add_random_row(input int k);
        logic [7:0]  c;
        logic [14:0] regs;
        logic        st;
        logic [3:0]  mem;
        for (int b = 0; b < 8; b++) begin
            c[b] = ($urandom % 8 == 0); // causes are rare
        end
        regs = {5'($urandom % 4), 5'($urandom % 4), 5'($urandom % 4)};
        st   = $urandom % 2;
        mem  = {~st & 1'($urandom % 2), 1'($urandom % 4 != 0), st, 1'($urandom % 3 == 0)};
        add_row($sformatf("rand_%0d", k), c, regs, mem,
                32'h4000 | (($urandom % 4) << 2) | ($urandom % 4), '0, '0,
                pipe_ctrl_pkg::cause_none, 1'b0, 1, 1'b1);
    endtask

    task automatic model_expect(output pipe_ctrl_pkg::stage_mask_t wr,
                                output pipe_ctrl_pkg::stage_mask_t fl,
                                output pipe_ctrl_pkg::cause_e c, output logic dreq);
        logic lu;
        logic sc;
        lu = mem_load && (mem_rt != 0) && (mem_rt == id_rs || mem_rt == id_rt);
        sc = mem_req && !mem_cached &&
            ((m2_st && m2_addr[31:`PC_WORD_LSB] == mem_addr[31:`PC_WORD_LSB]) ||
             (wb_st && wb_addr[31:`PC_WORD_LSB] == mem_addr[31:`PC_WORD_LSB]));
        if (causes[7]) c = pipe_ctrl_pkg::cause_exception;
        else if (causes[6] || causes[5]) c = pipe_ctrl_pkg::cause_dstall;
        else if (sc) c = pipe_ctrl_pkg::cause_store_conflict;
        else if (causes[4]) c = pipe_ctrl_pkg::cause_muldiv;
        else if (lu) c = pipe_ctrl_pkg::cause_load_use;
        else if (causes[3] || causes[2]) c = pipe_ctrl_pkg::cause_istall;
        else if (causes[1]) c = pipe_ctrl_pkg::cause_branch;
        else if (causes[0]) c = pipe_ctrl_pkg::cause_jump;
        else c = pipe_ctrl_pkg::cause_none;
        case (c)
            pipe_ctrl_pkg::cause_exception:      {wr, fl} = {7'h7f, 7'h1e};
            pipe_ctrl_pkg::cause_dstall:         {wr, fl} = {7'h00, 7'h00};
            pipe_ctrl_pkg::cause_store_conflict: {wr, fl} = {7'h60, 7'h20};
            pipe_ctrl_pkg::cause_muldiv:         {wr, fl} = {7'h70, 7'h10};
            pipe_ctrl_pkg::cause_load_use:       {wr, fl} = {7'h78, 7'h08};
            pipe_ctrl_pkg::cause_istall:         {wr, fl} = {7'h7c, 7'h04};
            pipe_ctrl_pkg::cause_branch:         {wr, fl} = {7'h7f, 7'h06};
            pipe_ctrl_pkg::cause_jump:           {wr, fl} = {7'h7f, 7'h02};
            default:                             {wr, fl} = {7'h7f, 7'h00};
        endcase
        dreq = mem_req && !(causes[7] || sc);
    endtask

    // slot update at the coming edge where wb reads the old mem2 entry
    task automatic model_advance(input pipe_ctrl_pkg::stage_mask_t wr,
                                 input pipe_ctrl_pkg::stage_mask_t fl);
        if (wr[`PC_S_WB]) begin
            wb_addr = m2_addr;
            wb_st   = m2_st & ~fl[`PC_S_WB];
        end
        if (wr[`PC_S_MEM2]) begin
            m2_addr = mem_addr;
            m2_st   = mem_store & ~fl[`PC_S_MEM2];
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s: %s expected %0h actual %0h", test, what, expected, actual);
            row_errors++;
        end
    endtask

    task automatic build_table();
        // power-on idle then every cause removed from the top down
        add_row("reset_idle", 8'h00, 15'h0, 4'b0000, 32'h0,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 0, 2, 0);
        add_row("reset_req", 8'h00, 15'h0, 4'b0101, 32'h0,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("all_pre_store", 8'h00, {5'd5, 5'd0, 5'd5}, 4'b0110, 32'h100,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("all_exception", 8'hff, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h7f, 7'h1e, pipe_ctrl_pkg::cause_exception, 0, 1, 0);
        add_row("all_dcache", 8'h7f, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h00, 7'h00, pipe_ctrl_pkg::cause_dstall, 0, 1, 0);
        add_row("all_dtlb", 8'h3f, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h00, 7'h00, pipe_ctrl_pkg::cause_dstall, 0, 1, 0);
        add_row("all_conflict", 8'h1f, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h60, 7'h20, pipe_ctrl_pkg::cause_store_conflict, 0, 1, 0);
        add_row("all_muldiv", 8'h1f, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h70, 7'h10, pipe_ctrl_pkg::cause_muldiv, 1, 1, 0);
        add_row("all_load_use", 8'h0f, {5'd5, 5'd0, 5'd5}, 4'b1100, 32'h101,
                7'h78, 7'h08, pipe_ctrl_pkg::cause_load_use, 1, 1, 0);
        add_row("all_icache", 8'h0f, {5'd5, 5'd0, 5'd5}, 4'b0100, 32'h101,
                7'h7c, 7'h04, pipe_ctrl_pkg::cause_istall, 1, 1, 0);
        add_row("all_itlb", 8'h07, {5'd5, 5'd0, 5'd5}, 4'b0100, 32'h101,
                7'h7c, 7'h04, pipe_ctrl_pkg::cause_istall, 1, 1, 0);
        add_row("all_branch", 8'h03, {5'd5, 5'd0, 5'd5}, 4'b0100, 32'h101,
                7'h7f, 7'h06, pipe_ctrl_pkg::cause_branch, 1, 1, 0);
        add_row("all_jump", 8'h01, {5'd5, 5'd0, 5'd5}, 4'b0100, 32'h101,
                7'h7f, 7'h02, pipe_ctrl_pkg::cause_jump, 1, 1, 0);
        add_row("all_none", 8'h00, {5'd5, 5'd0, 5'd5}, 4'b0100, 32'h101,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        // load-use against the memory stage
        add_row("lu_rs", 8'h00, {5'd7, 5'd3, 5'd7}, 4'b1000, 32'h0,
                7'h78, 7'h08, pipe_ctrl_pkg::cause_load_use, 0, 1, 0);
        add_row("lu_rt", 8'h00, {5'd2, 5'd9, 5'd9}, 4'b1000, 32'h0,
                7'h78, 7'h08, pipe_ctrl_pkg::cause_load_use, 0, 1, 0);
        add_row("lu_r0", 8'h00, 15'h0, 4'b1000, 32'h0,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 0, 1, 0);
        add_row("lu_nomatch", 8'h00, {5'd1, 5'd2, 5'd3}, 4'b1000, 32'h0,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 0, 1, 0);
        add_row("lu_no_load", 8'h00, {5'd7, 5'd3, 5'd7}, 4'b0000, 32'h0,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 0, 1, 0);
        // uncached store followed by a load to the same word
        add_row("st_uncached", 8'h00, 15'h0, 4'b0110, 32'h1000,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("ld_conflict", 8'h00, 15'h0, 4'b1100, 32'h1003,
                7'h60, 7'h20, pipe_ctrl_pkg::cause_store_conflict, 0, 2, 0);
        add_row("ld_drained", 8'h00, 15'h0, 4'b1100, 32'h1003,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("st_uncached2", 8'h00, 15'h0, 4'b0110, 32'h2000,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("ld_cached", 8'h00, 15'h0, 4'b1101, 32'h2000,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("ld_other_word", 8'h00, 15'h0, 4'b1100, 32'h2004,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        // slots hold under a data-side stall
        add_row("st_uncached3", 8'h00, 15'h0, 4'b0110, 32'h3000,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        add_row("ld_dstall_hold", 8'h40, 15'h0, 4'b1100, 32'h3002,
                7'h00, 7'h00, pipe_ctrl_pkg::cause_dstall, 0, 3, 0);
        add_row("ld_conflict_back", 8'h00, 15'h0, 4'b1100, 32'h3002,
                7'h60, 7'h20, pipe_ctrl_pkg::cause_store_conflict, 0, 2, 0);
        add_row("ld_after_hold", 8'h00, 15'h0, 4'b1100, 32'h3002,
                7'h7f, 7'h00, pipe_ctrl_pkg::cause_none, 1, 1, 0);
        for (int k = 0; k < 24; k++) begin
            add_random_row(k);
        end
    endtask

    initial begin
        int                         seed_ret;
        longint                     total_steps;
        pipe_ctrl_pkg::stage_mask_t e_wr;
        pipe_ctrl_pkg::stage_mask_t e_fl;
        pipe_ctrl_pkg::cause_e      e_cause;
        logic                       e_dreq;
        seed_ret   = $urandom(32'hcfc1);
        rst_n      = 1'b0;
        causes     = '0;
        {id_rs, id_rt, mem_rt} = '0;
        {mem_load, mem_req, mem_store, mem_cached} = '0;
        mem_addr   = '0;
        m2_addr    = '0;
        wb_addr    = '0;
        m2_st      = 1'b0;
        wb_st      = 1'b0;
        tests_pass = 0;
        tests_fail = 0;
        build_table();
        total_steps = 0;
        foreach (t_steps[i]) total_steps += t_steps[i];
        limit_ns = (total_steps + 16 + 4) * 100;
        repeat (16) @(posedge aclk);
        #5 rst_n = 1'b1;
        foreach (t_name[i]) begin
            row_errors = 0;
            for (int s = 0; s < t_steps[i]; s++) begin
                @(posedge aclk);
                #5;
                causes = t_causes[i];
                {id_rs, id_rt, mem_rt} = t_regs[i];
                {mem_load, mem_req, mem_store, mem_cached} = t_mem[i];
                mem_addr = t_addr[i];
                #90; // just before the next edge
                model_expect(e_wr, e_fl, e_cause, e_dreq);
                model_advance(e_wr, e_fl);
                if (!t_model[i]) begin
                    e_wr    = t_wr[i];
                    e_fl    = t_flush[i];
                    e_cause = t_cause[i];
                    e_dreq  = t_dreq[i];
                end
                check_value(t_name[i], "stage_wr", e_wr, stage_wr);
                check_value(t_name[i], "stage_flush", e_fl, stage_flush);
                check_value(t_name[i], "cause", e_cause, cause);
                check_value(t_name[i], "dreq_valid", e_dreq, dreq_valid);
                check_value(t_name[i], "ireq_valid", e_wr[`PC_S_PREIF], ireq_valid);
            end
            if (row_errors == 0) begin
                tests_pass++;
                $display("test %s passed", t_name[i]);
            end else begin
                tests_fail++;
                $display("test %s failed with %0d mismatches", t_name[i], row_errors);
            end
        end
        $display("summary: %0d tests passed, %0d tests failed", tests_pass, tests_fail);
        if (tests_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog: the test table did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pipe_ctrl_pkg.sv
      - rtl/store_slot_if.sv
      - rtl/store_track.sv
      - rtl/hazard_detect.sv
      - rtl/stall_arbiter.sv
      - rtl/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_pipe_ctrl_top.sv

/* src.f */
+incdir+rtl
rtl/pipe_ctrl_pkg.sv
rtl/store_slot_if.sv
rtl/store_track.sv
rtl/hazard_detect.sv
rtl/stall_arbiter.sv
rtl/pipe_ctrl_top.sv
test/tb_pipe_ctrl_top.sv
